/* hw/hash2qid_pkg.sv */
package hash2qid_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int num_tables   = 4;
    localparam int table_depth  = 128;
    localparam int qid_wid      = 12;
    localparam int tbl_sel_wid  = $clog2(num_tables);
    localparam int tbl_idx_wid  = $clog2(table_depth);
    localparam int tbl_addr_wid = tbl_sel_wid + tbl_idx_wid;
    localparam int wb_adr_wid   = 10;
    localparam int wb_dat_wid   = 32;

    // Address space select in the top bit of the bus address
    localparam logic space_regs   = 1'b0;
    localparam logic space_tables = 1'b1;

    // ==============================
    // Stream metadata
    // ==============================
    typedef logic [1:0] port_t;

    typedef struct packed {
        logic               last;
        port_t              tid;
        port_t              tdest;
        logic               rss_enable;
        logic [qid_wid-1:0] rss_entropy;
    } stream_meta_t;

    // ==============================
    // Wishbone bundles
    // ==============================
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [wb_adr_wid-1:0] adr;
        logic [wb_dat_wid-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [wb_dat_wid-1:0] dat;
    } wb_rsp_t;

    // Two decodings of the same 10-bit address
    typedef struct packed {
        logic                   space;
        logic [6:0]             unused;
        logic [tbl_sel_wid-1:0] sel;
    } wb_reg_addr_t;

    typedef struct packed {
        logic                   space;
        logic [tbl_sel_wid-1:0] tbl;
        logic [tbl_idx_wid-1:0] idx;
    } wb_tbl_addr_t;

    typedef union packed {
        wb_reg_addr_t reg_view;
        wb_tbl_addr_t tbl_view;
    } wb_addr_u;

endpackage

/* hw/qid_table_ram.sv */
module qid_table_ram (
    input  logic                                  core_clk,
    input  logic                                  wr_en,
    input  logic [hash2qid_pkg::tbl_addr_wid-1:0] wr_addr,
    input  logic [hash2qid_pkg::qid_wid-1:0]      wr_data,
    input  logic                                  rd_en,
    input  logic [hash2qid_pkg::tbl_addr_wid-1:0] rd_addr,
    output logic [hash2qid_pkg::qid_wid-1:0]      rd_data
);

    // ==============================
    // Storage
    // ==============================
    // Four tables stacked with the table select in the upper address bits
    localparam int depth = hash2qid_pkg::num_tables * hash2qid_pkg::table_depth;

    logic [hash2qid_pkg::qid_wid-1:0] mem [0:depth-1];

    // ==============================
    // Write port
    // ==============================
    always_ff @(posedge core_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ==============================
    // Read port
    // ==============================
    // Output register only loads on rd_en
    // so a stalled consumer keeps its entry
    always_ff @(posedge core_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hw/hash2qid_regs.sv */
module hash2qid_regs (
    input  logic                                       core_clk,
    input  logic                                       arst_n,
    input  hash2qid_pkg::wb_req_t                      wb_req,
    output hash2qid_pkg::wb_rsp_t                      wb_rsp,
    output logic                                       wr_en,
    output logic [hash2qid_pkg::tbl_addr_wid-1:0]      wr_addr,
    output logic [hash2qid_pkg::qid_wid-1:0]           wr_data,
    output logic [hash2qid_pkg::num_tables-1:0][hash2qid_pkg::qid_wid-1:0] base_qid
);

    // ==============================
    // Address decode
    // ==============================
    hash2qid_pkg::wb_addr_u addr;

    logic                                 req;
    logic                                 acc;
    logic                                 ack_q;
    logic                                 reg_wr;
    logic [hash2qid_pkg::wb_dat_wid-1:0]  rd_dat_q;
    logic [hash2qid_pkg::wb_dat_wid-1:0]  rd_dat_nxt;

    assign addr = wb_req.adr;

    // New access seen outside the ack cycle so ack is a single pulse
    assign req = wb_req.cyc & wb_req.stb & ~ack_q;

    // Cycle in which the access completes
    assign acc = ack_q & wb_req.cyc & wb_req.stb;

    // ==============================
    // Handshake
    // ==============================
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Read mux
    always_comb begin
        rd_dat_nxt = '0;
        if (!wb_req.we && addr.reg_view.space == hash2qid_pkg::space_regs) begin
            rd_dat_nxt[hash2qid_pkg::qid_wid-1:0] = base_qid[addr.reg_view.sel];
        end
    end

    always_ff @(posedge core_clk) begin
        if (req) begin
            rd_dat_q <= rd_dat_nxt;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;

    // ==============================
    // Base queue registers
    // ==============================
    assign reg_wr = acc & wb_req.we &
                    (addr.reg_view.space == hash2qid_pkg::space_regs);

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            base_qid <= '0;
        end else if (reg_wr) begin
            base_qid[addr.reg_view.sel] <= wb_req.dat[hash2qid_pkg::qid_wid-1:0];
        end
    end

    // ==============================
    // Table write port
    // ==============================
    // Strobe lines up with the ack pulse
    assign wr_en   = acc & wb_req.we &
                     (addr.tbl_view.space == hash2qid_pkg::space_tables);
    assign wr_addr = {addr.tbl_view.tbl, addr.tbl_view.idx};
    assign wr_data = wb_req.dat[hash2qid_pkg::qid_wid-1:0];

endmodule

/* hw/hash2qid_pipe.sv */
module hash2qid_pipe #(
    parameter int data_byte_wid = 64
) (
    input  logic                                  core_clk,
    input  logic                                  arst_n,

    // Input stream
    input  logic                                  in_valid,
    output logic                                  in_ready,
    input  logic [data_byte_wid*8-1:0]            in_data,
    input  hash2qid_pkg::stream_meta_t            in_meta,

    // Output stream
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [data_byte_wid*8-1:0]            out_data,
    output hash2qid_pkg::stream_meta_t            out_meta,

    // Table memory
    output logic                                  rd_en,
    output logic [hash2qid_pkg::tbl_addr_wid-1:0] rd_addr,
    input  logic [hash2qid_pkg::qid_wid-1:0]      rd_data,

    // Base queue per function
    input  logic [hash2qid_pkg::num_tables-1:0][hash2qid_pkg::qid_wid-1:0] base_qid
);

    logic                              a_valid;
    logic [data_byte_wid*8-1:0]        a_data;
    hash2qid_pkg::stream_meta_t        a_meta;
    logic                              b_valid;
    logic [data_byte_wid*8-1:0]        b_data;
    hash2qid_pkg::stream_meta_t        b_meta;
    logic                              b_adv;
    logic                              in_xfer;
    logic [hash2qid_pkg::qid_wid-1:0]  a_base;
    logic [hash2qid_pkg::qid_wid-1:0]  a_offset;
    hash2qid_pkg::stream_meta_t        a_meta_qid;

    // ==============================
    // Flow control
    // ==============================
    assign b_adv    = ~b_valid | out_ready;
    assign in_ready = ~a_valid | b_adv;
    assign in_xfer  = in_valid & in_ready;

    // ==============================
    // Stage A
    // ==============================
    // Table read issued with the accepted beat
    // entropy[11:10] picks the function and entropy[6:0] the entry
    assign rd_en   = in_xfer;
    assign rd_addr = {in_meta.rss_entropy[11:10], in_meta.rss_entropy[6:0]};

    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            a_valid <= 1'b0;
        end else if (in_ready) begin
            a_valid <= in_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (in_xfer) begin
            a_data <= in_data;
            a_meta <= in_meta;
        end
    end

    // Queue ID wraps at 12 bits
    assign a_base   = base_qid[a_meta.rss_entropy[11:10]];
    assign a_offset = a_meta.rss_enable ? rd_data : '0;

    always_comb begin
        a_meta_qid             = a_meta;
        a_meta_qid.rss_entropy = a_base + a_offset;
        a_meta_qid.rss_enable  = 1'b1;
    end

    // ==============================
    // Stage B
    // ==============================
    always_ff @(posedge core_clk or negedge arst_n) begin
        if (!arst_n) begin
            b_valid <= 1'b0;
        end else if (b_adv) begin
            b_valid <= a_valid;
        end
    end

    always_ff @(posedge core_clk) begin
        if (b_adv && a_valid) begin
            b_data <= a_data;
            b_meta <= a_meta_qid;
        end
    end

    assign out_valid = b_valid;
    assign out_data  = b_data;
    assign out_meta  = b_meta;

endmodule

/* hw/hash2qid_top.sv */
module hash2qid_top #(
    parameter int data_byte_wid = 64
) (
    input  logic                       core_clk,
    input  logic                       arst_n,

    // Input stream
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [data_byte_wid*8-1:0] in_data,
    input  hash2qid_pkg::stream_meta_t in_meta,

    // Output stream
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [data_byte_wid*8-1:0] out_data,
    output hash2qid_pkg::stream_meta_t out_meta,

    // Register bus
    input  hash2qid_pkg::wb_req_t      wb_req,
    output hash2qid_pkg::wb_rsp_t      wb_rsp
);

    logic                                  wr_en;
    logic [hash2qid_pkg::tbl_addr_wid-1:0] wr_addr;
    logic [hash2qid_pkg::qid_wid-1:0]      wr_data;
    logic                                  rd_en;
    logic [hash2qid_pkg::tbl_addr_wid-1:0] rd_addr;
    logic [hash2qid_pkg::qid_wid-1:0]      rd_data;
    logic [hash2qid_pkg::num_tables-1:0][hash2qid_pkg::qid_wid-1:0] base_qid;

    // Register slave
    hash2qid_regs u_regs (
        .core_clk (core_clk),
        .arst_n   (arst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .base_qid (base_qid)
    );

    // Function tables
    qid_table_ram u_ram (
        .core_clk (core_clk),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // Stream pipeline
    hash2qid_pipe #(
        .data_byte_wid (data_byte_wid)
    ) u_pipe (
        .core_clk  (core_clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .in_meta   (in_meta),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_meta  (out_meta),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .base_qid  (base_qid)
    );

endmodule

/* testbench/hash2qid_tb.sv */
module hash2qid_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef hash2qid_pkg::stream_meta_t meta_t;

    localparam int data_byte_wid = 64;
    localparam int dw            = data_byte_wid * 8;
    localparam int clk_period    = 40;
    localparam int reset_cycles  = 16;
    // Bus accesses and beats over all tests including table setup
    localparam int n_access      = 533;
    localparam int n_beats       = 713;
    localparam real budget_ns    =
        1.5 * (reset_cycles + 2 * n_access + 4 * n_beats) * clk_period;

    logic                  core_clk = 1'b0;
    logic                  arst_n;
    logic                  in_valid;
    logic                  in_ready;
    logic [dw-1:0]         in_data;
    meta_t                 in_meta;
    logic                  out_valid;
    logic                  out_ready;
    logic [dw-1:0]         out_data;
    meta_t                 out_meta;
    hash2qid_pkg::wb_req_t wb_req;
    hash2qid_pkg::wb_rsp_t wb_rsp;

    logic [31:0]           rng;
    logic [31:0]           rdy_rng;
    bit                    rand_ready = 1'b0;
    int                    err_cnt = 0;
    int                    chk_cnt = 0;
    int                    test_cnt = 0;
    logic [11:0]           base_sh [4];
    logic [11:0]           tbl_sh [4][128];
    meta_t                 exp_meta_q [$];
    logic [dw-1:0]         exp_data_q [$];

    hash2qid_top #(.data_byte_wid(data_byte_wid)) DUT (.*);

    always #(clk_period / 2) core_clk = ~core_clk;

    // ==============================
    // Random numbers and addresses
    // ==============================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic logic [9:0] reg_addr(input logic [1:0] sel);
        hash2qid_pkg::wb_addr_u a;
        a = '0;
        a.reg_view.space = hash2qid_pkg::space_regs;
        a.reg_view.sel   = sel;
        return a;
    endfunction

    function automatic logic [9:0] tbl_addr(input logic [1:0] tbl, input logic [6:0] idx);
        hash2qid_pkg::wb_addr_u a;
        a.tbl_view.space = hash2qid_pkg::space_tables;
        a.tbl_view.tbl   = tbl;
        a.tbl_view.idx   = idx;
        return a;
    endfunction

    // Reference model of base plus table entry with 12-bit wrap
    function automatic meta_t model_meta(input meta_t m);
        meta_t      e;
        logic [1:0] f;
        f = m.rss_entropy[11:10];
        e = m;
        e.rss_enable  = 1'b1;
        e.rss_entropy = base_sh[f];
        if (m.rss_enable) begin
            e.rss_entropy = base_sh[f] + tbl_sh[f][m.rss_entropy[6:0]];
        end
        return e;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic note_check(input string name, input bit ok,
                              input logic [dw-1:0] exp, input logic [dw-1:0] act);
        chk_cnt++;
        if (!ok) begin
            err_cnt++;
            $display("** Error: %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_meta(input string name, input meta_t exp, input meta_t act);
        note_check(name, act === exp, exp, act);
    endtask

    task automatic check_data(input string name, input logic [dw-1:0] exp,
                              input logic [dw-1:0] act);
        note_check(name, act === exp, exp, act);
    endtask

    task automatic check_wb(input string name, input logic [31:0] exp, input logic [31:0] act);
        note_check(name, act === exp, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        note_check(name, act === exp, exp, act);
    endtask

    // ==============================
    // Bus and stream drivers
    // ==============================
    task automatic wb_write(input logic [9:0] adr, input logic [31:0] dat);
        @(posedge core_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        do @(posedge core_clk); while (!wb_rsp.ack);
        wb_req <= '0;
    endtask

    task automatic wb_read(input logic [9:0] adr, output logic [31:0] dat);
        @(posedge core_clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
        do @(posedge core_clk); while (!wb_rsp.ack);
        dat = wb_rsp.dat;
        wb_req <= '0;
    endtask

    task automatic table_init();
        for (int t = 0; t < 4; t++) begin
            base_sh[t] = {~t[1:0], 10'h0};
            wb_write(reg_addr(t[1:0]), base_sh[t]);
            for (int j = 0; j < 128; j++) begin
                tbl_sh[t][j] = {2'b0, ~t[1:0], 8'h0} + {5'h0, ~j[6:0]};
                wb_write(tbl_addr(t[1:0], j[6:0]), tbl_sh[t][j]);
            end
        end
    endtask

    // Mode selects RSS off (0), on (1) or random per beat (2)
    task automatic send_beats(input int n, input int mode, input bit gaps);
        logic [31:0]   r;
        logic [dw-1:0] d;
        meta_t         m;
        @(posedge core_clk);
        for (int i = 0; i < n; i++) begin
            r = rand32();
            for (int w = 0; w < dw / 32; w++) begin
                d[w*32 +: 32] = rand32();
            end
            m = r[17:0];
            if (mode < 2) begin
                m.rss_enable = mode[0];
            end
            if (gaps && r[31:30] != 2'd0) begin
                in_valid <= 1'b0;
                repeat (r[31:30]) @(posedge core_clk);
            end
            exp_meta_q.push_back(model_meta(m));
            exp_data_q.push_back(d);
            in_valid <= 1'b1;
            in_data  <= d;
            in_meta  <= m;
            do @(posedge core_clk); while (!in_ready);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        int k;
        k = 0;
        while (exp_meta_q.size() != 0 && k < 500) begin
            @(posedge core_clk);
            k++;
        end
        if (exp_meta_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected beats never came out", exp_meta_q.size());
            exp_meta_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_cnt++;
        $display("%s done, %0d errors", name, err_cnt - errs_before);
    endtask

    // Output monitor
    always @(posedge core_clk) begin
        if (arst_n && out_valid && out_ready) begin
            if (exp_meta_q.size() == 0) begin
                err_cnt++;
                $display("Output beat arrived with no input beat pending");
            end else begin
                check_meta("out_meta", exp_meta_q.pop_front(), out_meta);
                check_data("out_data", exp_data_q.pop_front(), out_data);
            end
        end
    end

    always @(posedge core_clk) begin
        rdy_rng = xorshift(rdy_rng);
        out_ready <= rand_ready ? rdy_rng[7] : 1'b1;
    end

    // ==============================
    // Tests
    // ==============================
    task automatic reset_values();
        int          e0;
        logic [31:0] d;
        e0 = err_cnt;
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("wb_rsp.ack", 1'b0, wb_rsp.ack);
        check_bit("in_ready", 1'b1, in_ready);
        for (int s = 0; s < 4; s++) begin
            wb_read(reg_addr(s[1:0]), d);
            check_wb("wb_rsp.dat", 32'h0, d);
        end
        end_test("reset_values", e0);
    endtask

    task automatic base_reg_access();
        int          e0;
        logic [31:0] v;
        logic [31:0] d;
        e0 = err_cnt;
        // All four written before any is read back
        for (int s = 0; s < 4; s++) begin
            v = rand32();
            base_sh[s] = v[11:0];
            wb_write(reg_addr(s[1:0]), v);
        end
        for (int s = 0; s < 4; s++) begin
            wb_read(reg_addr(s[1:0]), d);
            check_wb("wb_rsp.dat", {20'h0, base_sh[s]}, d);
        end
        // Tables are write-only
        v = rand32();
        wb_read(tbl_addr(v[1:0], v[8:2]), d);
        check_wb("wb_rsp.dat", 32'h0, d);
        end_test("base_reg_access", e0);
    endtask

    task automatic rss_mapping(input bit en);
        int e0;
        e0 = err_cnt;
        send_beats(256, {31'h0, en}, 1'b0);
        drain();
        end_test(en ? "rss_enabled" : "rss_disabled", e0);
    endtask

    task automatic back_pressure();
        int          e0;
        int          lat;
        logic [31:0] v;
        e0 = err_cnt;
        // Random bases so that some sums wrap past 12 bits
        for (int s = 0; s < 4; s++) begin
            v = rand32();
            base_sh[s] = v[11:0];
            wb_write(reg_addr(s[1:0]), v);
        end
        rand_ready = 1'b1;
        send_beats(200, 2, 1'b1);
        drain();
        rand_ready = 1'b0;
        repeat (2) @(posedge core_clk);
        // Single beat through an idle pipeline
        send_beats(1, 2, 1'b0);
        lat = 0;
        do begin
            @(posedge core_clk);
            lat++;
        end while (!(out_valid && out_ready) && lat < 8);
        if (lat != 2) begin
            err_cnt++;
            $display("Single beat took %0d cycles to come out instead of 2", lat);
        end
        drain();
        end_test("back_pressure", e0);
    endtask

    initial begin
        rng       = 32'h5236;
        rdy_rng   = ~32'h5236;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_meta   = '0;
        out_ready = 1'b1;
        wb_req    = '0;
        repeat (reset_cycles) @(posedge core_clk);
        arst_n <= 1'b1;
        @(posedge core_clk);
        reset_values();
        base_reg_access();
        table_init();
        rss_mapping(1'b0);
        rss_mapping(1'b1);
        back_pressure();
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(budget_ns);
        $display("Watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
hw/hash2qid_pkg.sv
hw/qid_table_ram.sv
hw/hash2qid_regs.sv
hw/hash2qid_pipe.sv
hw/hash2qid_top.sv
testbench/hash2qid_tb.sv
